// ==== source/accel_pkg.sv ====
`default_nettype none

package accel_pkg;

  // host port and packet memory
  localparam int IO_ADDR_W   = 12;
  localparam int IO_DATA_W   = 32;
  localparam int PMEM_ADDR_W = 10;
  localparam int LEN_W       = 14;
  localparam int IDX_W       = 16;

  // matcher fifo depth, also the dma's starting credit count
  localparam int CREDITS  = 4;
  localparam int CREDIT_W = $clog2(CREDITS + 1);
  localparam int FIFO_AW  = $clog2(CREDITS);
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(CREDITS);

  // word offset inside a window, address bits 5:2
  typedef enum logic [3:0] {
    OFF_CTRL      = 4'h0,
    OFF_LEN       = 4'h1,
    OFF_ADDR      = 4'h2,
    OFF_MATCH_IDX = 4'h3,
    OFF_PATTERN   = 4'h4,
    OFF_ERROR     = 4'h5,
    OFF_RELEASE   = 4'hA
  } reg_off_e;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WAIT_CREDIT
  } dma_state_e;

  typedef enum logic [1:0] {
    M_IDLE,
    M_SCAN,
    M_HOLD
  } match_state_e;

endpackage

`default_nettype wire

// ==== source/accel_mmio_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module accel_mmio_regs (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  io_en,
  input  wire                                  io_wen,
  input  wire [accel_pkg::IO_ADDR_W-1:0]       io_addr,
  input  wire [accel_pkg::IO_DATA_W-1:0]       io_wr_data,
  input  wire [accel_pkg::IO_DATA_W-1:0]       status_word,
  input  wire [accel_pkg::IDX_W-1:0]           match_idx,
  input  wire [accel_pkg::IO_DATA_W-1:0]       error_word,
  input  wire                                  match_or_done,
  input  wire                                  ip_result,
  input  wire                                  ip_done,
  output logic [accel_pkg::IO_DATA_W-1:0]      io_rd_data,
  output logic                                 io_rd_valid,
  output logic                                 cmd_start,
  output logic                                 cmd_stop,
  output logic [accel_pkg::PMEM_ADDR_W-1:0]    cmd_addr,
  output logic [accel_pkg::LEN_W-1:0]          cmd_len,
  output logic [accel_pkg::IO_DATA_W-1:0]      pattern,
  output logic                                 release_match,
  output logic [accel_pkg::IO_DATA_W-1:0]      ip_addr,
  output logic                                 ip_valid,
  output logic [accel_pkg::IO_DATA_W-1:0]      ip_prefix,
  output logic [accel_pkg::IO_DATA_W-1:0]      ip_mask
);

  accel_pkg::reg_off_e             off;
  logic                            ip_win;
  logic                            agg_win;
  logic                            wr_cmd;
  logic                            wr_ip;
  logic                            rd_req;
  logic                            rd_stall;
  logic                            stall_rd;
  logic                            stall_cond;
  logic [accel_pkg::IO_DATA_W-1:0] rd_mux;

  assign off     = accel_pkg::reg_off_e'(io_addr[5:2]);
  assign ip_win  = io_addr[11];
  assign agg_win = !io_addr[11] && io_addr[10];
  assign wr_cmd  = io_en && io_wen && !io_addr[11] && !io_addr[10];
  assign wr_ip   = io_en && io_wen && ip_win;
  assign rd_req  = io_en && !io_wen;

  // match index and ip result wait for their engine
  assign stall_rd = ip_win ? (off == accel_pkg::OFF_CTRL)
                           : (!agg_win && off == accel_pkg::OFF_MATCH_IDX);
  // a start or submit still in flight means the flags are stale
  assign stall_cond = ip_win ? (ip_done && !ip_valid) : (match_or_done && !cmd_start);

  always_comb begin
    rd_mux = '0;
    if (ip_win) begin
      case (off)
        accel_pkg::OFF_CTRL: rd_mux[0] = ip_result;
        accel_pkg::OFF_LEN:  rd_mux    = ip_prefix;
        accel_pkg::OFF_ADDR: rd_mux    = ip_mask;
        default: ;
      endcase
    end else if (agg_win) begin
      if (off == accel_pkg::OFF_CTRL)
        rd_mux = status_word;
    end else begin
      case (off)
        accel_pkg::OFF_CTRL:      rd_mux = status_word;
        accel_pkg::OFF_LEN:       rd_mux[accel_pkg::LEN_W-1:0] = cmd_len;
        accel_pkg::OFF_ADDR:      rd_mux[accel_pkg::PMEM_ADDR_W-1:0] = cmd_addr;
        accel_pkg::OFF_MATCH_IDX: rd_mux[accel_pkg::IDX_W-1:0] = match_idx;
        accel_pkg::OFF_PATTERN:   rd_mux = pattern;
        accel_pkg::OFF_ERROR:     rd_mux = error_word;
        default: ;
      endcase
    end
  end

  // held configuration
  always_ff @(posedge clk) begin
    if (wr_cmd && off == accel_pkg::OFF_LEN)
      cmd_len <= io_wr_data[accel_pkg::LEN_W-1:0];
    if (wr_cmd && off == accel_pkg::OFF_ADDR)
      cmd_addr <= io_wr_data[accel_pkg::PMEM_ADDR_W-1:0];
    if (wr_cmd && off == accel_pkg::OFF_PATTERN)
      pattern <= io_wr_data;
    if (wr_ip && off == accel_pkg::OFF_CTRL)
      ip_addr <= io_wr_data;
    if (wr_ip && off == accel_pkg::OFF_LEN)
      ip_prefix <= io_wr_data;
    if (wr_ip && off == accel_pkg::OFF_ADDR)
      ip_mask <= io_wr_data;
    if (rd_req || rd_stall)
      io_rd_data <= rd_mux;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_start     <= 1'b0;
      cmd_stop      <= 1'b0;
      release_match <= 1'b0;
      ip_valid      <= 1'b0;
      io_rd_valid   <= 1'b0;
      rd_stall      <= 1'b0;
    end else begin
      cmd_start     <= wr_cmd && off == accel_pkg::OFF_CTRL && io_wr_data[0];
      cmd_stop      <= wr_cmd && off == accel_pkg::OFF_CTRL && io_wr_data[4];
      release_match <= wr_cmd && off == accel_pkg::OFF_RELEASE && io_wr_data[0];
      ip_valid      <= wr_ip && off == accel_pkg::OFF_CTRL;
      // host keeps io_addr steady, so a stalled read is simply repeated
      if (rd_req || rd_stall) begin
        io_rd_valid <= stall_rd ? stall_cond : 1'b1;
        rd_stall    <= stall_rd && !stall_cond;
      end else begin
        io_rd_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pmem_rd_dma.sv ====
`timescale 1ns/10ps
`default_nettype none

module pmem_rd_dma (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  cmd_start,
  input  wire                                  cmd_stop,
  input  wire [accel_pkg::PMEM_ADDR_W-1:0]     cmd_addr,
  input  wire [accel_pkg::LEN_W-1:0]           cmd_len,
  input  wire [accel_pkg::IO_DATA_W-1:0]       mem_rd_data,
  input  wire                                  credit,
  output logic                                 mem_rd_en,
  output logic [accel_pkg::PMEM_ADDR_W-1:0]    mem_rd_addr,
  output logic                                 wd_valid,
  output logic [accel_pkg::IO_DATA_W-1:0]      wd_data,
  output logic [2:0]                           wd_bytes,
  output logic                                 wd_last,
  output logic                                 busy,
  output logic                                 desc_error
);

  accel_pkg::dma_state_e             state;
  logic [accel_pkg::CREDIT_W-1:0]    credit_cnt;
  logic [accel_pkg::CREDIT_W-1:0]    credit_nxt;
  logic [accel_pkg::LEN_W:0]         len_up;
  logic [accel_pkg::LEN_W:0]         n_words;
  logic [accel_pkg::LEN_W:0]         end_word;
  logic                              desc_bad;
  logic [accel_pkg::LEN_W-2:0]       words_left;
  logic [2:0]                        last_bytes;
  logic                              last_rd;
  logic [accel_pkg::PMEM_ADDR_W-1:0] mem_rd_addr_q;

  // word count rounded up, then the end must stay inside the memory
  assign len_up   = cmd_len + 2'd3;
  assign n_words  = len_up >> 2;
  assign end_word = n_words + cmd_addr;
  assign desc_bad = (cmd_len == '0) || (end_word > (1 << accel_pkg::PMEM_ADDR_W));

  assign mem_rd_en   = (state == accel_pkg::DMA_READ) && (credit_cnt != '0);
  assign mem_rd_addr = mem_rd_addr_q;
  assign wd_data     = mem_rd_data;
  assign busy        = (state != accel_pkg::DMA_IDLE);
  assign last_rd     = mem_rd_en && (words_left == 1);
  assign credit_nxt  = credit_cnt - mem_rd_en + credit;

  always_ff @(posedge clk) begin
    if (state == accel_pkg::DMA_IDLE && cmd_start) begin
      mem_rd_addr_q <= cmd_addr;
      words_left    <= n_words[accel_pkg::LEN_W-2:0];
      last_bytes    <= (cmd_len[1:0] == 2'd0) ? 3'd4 : {1'b0, cmd_len[1:0]};
    end else if (mem_rd_en) begin
      mem_rd_addr_q <= mem_rd_addr_q + 1'b1;
      words_left    <= words_left - 1'b1;
    end
    wd_bytes <= last_rd ? last_bytes : 3'd4;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= accel_pkg::DMA_IDLE;
      credit_cnt <= accel_pkg::CREDIT_MAX;
      wd_valid   <= 1'b0;
      wd_last    <= 1'b0;
      desc_error <= 1'b0;
    end else begin
      wd_valid   <= mem_rd_en;
      wd_last    <= last_rd;
      desc_error <= 1'b0;
      credit_cnt <= credit_nxt;
      case (state)
        accel_pkg::DMA_IDLE: begin
          if (cmd_start && desc_bad) begin
            desc_error <= 1'b1;
          end else if (cmd_start) begin
            state      <= accel_pkg::DMA_READ;
            credit_cnt <= accel_pkg::CREDIT_MAX;
          end
        end
        accel_pkg::DMA_READ: begin
          if (last_rd)
            state <= accel_pkg::DMA_IDLE;
          else if (credit_nxt == '0)
            state <= accel_pkg::DMA_WAIT_CREDIT;
        end
        accel_pkg::DMA_WAIT_CREDIT: begin
          if (credit)
            state <= accel_pkg::DMA_READ;
        end
        default: state <= accel_pkg::DMA_IDLE;
      endcase
      if (cmd_stop)
        state <= accel_pkg::DMA_IDLE;
    end
  end

endmodule

`default_nettype wire

// ==== source/byte_pattern_matcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_pattern_matcher (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  cmd_start,
  input  wire                                  cmd_stop,
  input  wire [accel_pkg::IO_DATA_W-1:0]       pattern,
  input  wire                                  release_match,
  input  wire                                  wd_valid,
  input  wire [accel_pkg::IO_DATA_W-1:0]       wd_data,
  input  wire [2:0]                            wd_bytes,
  input  wire                                  wd_last,
  output logic                                 credit,
  output logic                                 m_match,
  output logic [accel_pkg::IDX_W-1:0]          m_index,
  output logic                                 m_done
);

  accel_pkg::match_state_e          state;
  logic [accel_pkg::IO_DATA_W-1:0]  fifo_data  [accel_pkg::CREDITS];
  logic [2:0]                       fifo_bytes [accel_pkg::CREDITS];
  logic                             fifo_last  [accel_pkg::CREDITS];
  logic [accel_pkg::FIFO_AW-1:0]    wr_ptr;
  logic [accel_pkg::FIFO_AW-1:0]    rd_ptr;
  logic [accel_pkg::FIFO_AW:0]      fifo_cnt;
  logic [1:0]                       byte_sel;
  logic [accel_pkg::IDX_W-1:0]      byte_cnt;
  logic [accel_pkg::IO_DATA_W-1:0]  window;
  logic [accel_pkg::IO_DATA_W-1:0]  new_win;
  logic [7:0]                       cur_byte;
  logic                             scan_en;
  logic                             word_end;
  logic                             pkt_end;
  logic                             hit;
  logic                             pop;
  logic                             hold_last;

  // little-endian byte order within a word
  assign cur_byte = fifo_data[rd_ptr][byte_sel*8 +: 8];
  // oldest byte sits in the low lane, like pattern byte 0
  assign new_win  = {cur_byte, window[31:8]};
  assign scan_en  = (state == accel_pkg::M_SCAN) && (fifo_cnt != '0);
  assign word_end = ({1'b0, byte_sel} == fifo_bytes[rd_ptr] - 3'd1);
  assign pkt_end  = word_end && fifo_last[rd_ptr];
  assign hit      = scan_en && (byte_cnt >= 3) && (new_win == pattern);
  assign pop      = scan_en && word_end && !cmd_start && !cmd_stop;

  always_ff @(posedge clk) begin
    if (wd_valid) begin
      fifo_data[wr_ptr]  <= wd_data;
      fifo_bytes[wr_ptr] <= wd_bytes;
      fifo_last[wr_ptr]  <= wd_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= accel_pkg::M_IDLE;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
      credit   <= 1'b0;
      m_match  <= 1'b0;
      m_done   <= 1'b0;
    end else begin
      credit  <= pop;
      m_match <= 1'b0;
      m_done  <= 1'b0;
      if (cmd_start || cmd_stop) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        fifo_cnt <= '0;
      end else begin
        wr_ptr   <= wr_ptr + wd_valid;
        rd_ptr   <= rd_ptr + pop;
        fifo_cnt <= fifo_cnt + wd_valid - pop;
      end

      if (cmd_start) begin
        state    <= accel_pkg::M_SCAN;
        window   <= '0;
        byte_cnt <= '0;
        byte_sel <= 2'd0;
      end else if (cmd_stop) begin
        state  <= accel_pkg::M_IDLE;
        m_done <= 1'b1;
      end else begin
        case (state)
          accel_pkg::M_SCAN: begin
            if (scan_en) begin
              window   <= new_win;
              byte_cnt <= byte_cnt + 1'b1;
              byte_sel <= word_end ? 2'd0 : byte_sel + 1'b1;
              if (hit) begin
                state     <= accel_pkg::M_HOLD;
                m_match   <= 1'b1;
                m_index   <= byte_cnt;
                hold_last <= pkt_end;
              end else if (pkt_end) begin
                state  <= accel_pkg::M_IDLE;
                m_done <= 1'b1;
              end
            end
          end
          accel_pkg::M_HOLD: begin
            // a hit on the final byte finishes once released
            if (release_match) begin
              state  <= hold_last ? accel_pkg::M_IDLE : accel_pkg::M_SCAN;
              m_done <= hold_last;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ip_prefix_matcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module ip_prefix_matcher (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire [accel_pkg::IO_DATA_W-1:0]       ip_addr,
  input  wire                                  ip_valid,
  input  wire [accel_pkg::IO_DATA_W-1:0]       ip_prefix,
  input  wire [accel_pkg::IO_DATA_W-1:0]       ip_mask,
  output logic                                 ip_match,
  output logic                                 ip_done
);

  logic [accel_pkg::IO_DATA_W-1:0] addr_host;
  logic                            addr_vld;

  // network order to host order
  always_ff @(posedge clk) begin
    if (ip_valid)
      addr_host <= {ip_addr[7:0], ip_addr[15:8], ip_addr[23:16], ip_addr[31:24]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_vld <= 1'b0;
      ip_match <= 1'b0;
      ip_done  <= 1'b0;
    end else begin
      addr_vld <= ip_valid;
      if (ip_valid) begin
        ip_match <= 1'b0;
        ip_done  <= 1'b0;
      end else if (addr_vld) begin
        ip_match <= (addr_host & ip_mask) == (ip_prefix & ip_mask);
        ip_done  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/accel_status.sv ====
`timescale 1ns/10ps
`default_nettype none

module accel_status (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  cmd_start,
  input  wire                                  busy,
  input  wire                                  desc_error,
  input  wire                                  m_match,
  input  wire [accel_pkg::IDX_W-1:0]           m_index,
  input  wire                                  m_done,
  input  wire                                  ip_match,
  input  wire                                  ip_done,
  output logic [accel_pkg::IO_DATA_W-1:0]      status_word,
  output logic [accel_pkg::IDX_W-1:0]          match_idx,
  output logic [accel_pkg::IO_DATA_W-1:0]      error_word,
  output logic                                 match_or_done,
  output logic                                 ip_result
);

  logic       done_flag;
  logic       match_flag;
  logic [1:0] err;

  always_ff @(posedge clk) begin
    if (m_match)
      match_idx <= m_index;
  end

  // sticky per job, a new start clears them
  always_ff @(posedge clk) begin
    if (rst || cmd_start) begin
      done_flag  <= 1'b0;
      match_flag <= 1'b0;
      err        <= 2'b00;
    end else begin
      done_flag  <= done_flag | m_done;
      match_flag <= match_flag | m_match;
      err[0]     <= err[0] | desc_error;
      err[1]     <= err[1] | (m_done & busy);
    end
  end

  always_comb begin
    status_word     = '0;
    status_word[1]  = busy;
    status_word[8]  = done_flag;
    status_word[9]  = match_flag;
    status_word[16] = ip_done;
    status_word[17] = ip_match;
  end

  assign error_word    = {{(accel_pkg::IO_DATA_W-2){1'b0}}, err};
  assign match_or_done = done_flag | match_flag;
  assign ip_result     = ip_match & ip_done;

endmodule

`default_nettype wire

// ==== source/accel_wrap.sv ====
`timescale 1ns/10ps
`default_nettype none

module accel_wrap (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  io_en,
  input  wire                                  io_wen,
  input  wire [accel_pkg::IO_ADDR_W-1:0]       io_addr,
  input  wire [accel_pkg::IO_DATA_W-1:0]       io_wr_data,
  output wire [accel_pkg::IO_DATA_W-1:0]       io_rd_data,
  output wire                                  io_rd_valid,
  output wire                                  mem_rd_en,
  output wire [accel_pkg::PMEM_ADDR_W-1:0]     mem_rd_addr,
  input  wire [accel_pkg::IO_DATA_W-1:0]       mem_rd_data
);

  // command side
  wire                                 cmd_start;
  wire                                 cmd_stop;
  wire [accel_pkg::PMEM_ADDR_W-1:0]    cmd_addr;
  wire [accel_pkg::LEN_W-1:0]          cmd_len;
  wire [accel_pkg::IO_DATA_W-1:0]      pattern;
  wire                                 release_match;
  wire [accel_pkg::IO_DATA_W-1:0]      ip_addr;
  wire                                 ip_valid;
  wire [accel_pkg::IO_DATA_W-1:0]      ip_prefix;
  wire [accel_pkg::IO_DATA_W-1:0]      ip_mask;

  // word stream with credit return
  wire                                 wd_valid;
  wire [accel_pkg::IO_DATA_W-1:0]      wd_data;
  wire [2:0]                           wd_bytes;
  wire                                 wd_last;
  wire                                 credit;

  // results
  wire                                 busy;
  wire                                 desc_error;
  wire                                 m_match;
  wire [accel_pkg::IDX_W-1:0]          m_index;
  wire                                 m_done;
  wire                                 ip_match;
  wire                                 ip_done;
  wire [accel_pkg::IO_DATA_W-1:0]      status_word;
  wire [accel_pkg::IDX_W-1:0]          match_idx;
  wire [accel_pkg::IO_DATA_W-1:0]      error_word;
  wire                                 match_or_done;
  wire                                 ip_result;

  accel_mmio_regs      u_regs   (.*);
  pmem_rd_dma          u_dma    (.*);
  byte_pattern_matcher u_match  (.*);
  ip_prefix_matcher    u_ip     (.*);
  accel_status         u_status (.*);

endmodule

`default_nettype wire

// ==== testbench/accel_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module accel_props (
  input wire                                 clk,
  input wire                                 rst,
  input wire                                 mem_rd_en,
  input wire                                 wd_valid,
  input wire [accel_pkg::CREDIT_W-1:0]       credit_cnt
);

  int unsigned fail_cnt = 0;

  // a read needs a free slot in the matcher fifo
  a_read_needs_credit: assert property (
    @(posedge clk) disable iff (rst) mem_rd_en |-> credit_cnt != '0
  ) else begin
    $error("memory read issued with no credit left");
    fail_cnt++;
  end

  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst) credit_cnt <= accel_pkg::CREDITS
  ) else begin
    $error("credit count above the fifo depth");
    fail_cnt++;
  end

  // each read word shows up on the stream one cycle later
  a_word_follows_read: assert property (
    @(posedge clk) disable iff (rst) wd_valid == $past(mem_rd_en)
  ) else begin
    $error("stream word does not follow its memory read");
    fail_cnt++;
  end

endmodule

bind pmem_rd_dma accel_props u_props (
  .clk        (clk),
  .rst        (rst),
  .mem_rd_en  (mem_rd_en),
  .wd_valid   (wd_valid),
  .credit_cnt (credit_cnt)
);

`default_nettype wire

// ==== testbench/accel_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module accel_tb;

  localparam int RD_TIMEOUT = 5000;
  localparam int POLL_LIMIT = 2000;
  localparam logic [accel_pkg::IO_ADDR_W-1:0] AGG_STATUS = 12'h400;
  localparam logic [accel_pkg::IO_DATA_W-1:0] PAT = 32'hA5C3_9EF1;

  logic                                clk;
  logic                                rst;
  logic                                io_en;
  logic                                io_wen;
  logic [accel_pkg::IO_ADDR_W-1:0]     io_addr;
  logic [accel_pkg::IO_DATA_W-1:0]     io_wr_data;
  wire  [accel_pkg::IO_DATA_W-1:0]     io_rd_data;
  wire                                 io_rd_valid;
  wire                                 mem_rd_en;
  wire  [accel_pkg::PMEM_ADDR_W-1:0]   mem_rd_addr;
  logic [accel_pkg::IO_DATA_W-1:0]     mem_rd_data;

  logic [accel_pkg::IO_DATA_W-1:0]     pmem [1 << accel_pkg::PMEM_ADDR_W];
  int unsigned                         rd_count;
  int unsigned                         errors;
  int unsigned                         checks;

  accel_wrap u_accel_wrap (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // packet memory, one cycle read latency
  always @(posedge clk) begin
    if (mem_rd_en)
      mem_rd_data <= pmem[mem_rd_addr];
  end

  always @(posedge clk) begin
    if (rst)
      rd_count <= 0;
    else if (mem_rd_en)
      rd_count <= rd_count + 1;
  end

  function automatic logic [accel_pkg::IO_ADDR_W-1:0] cmd_reg(accel_pkg::reg_off_e off);
    return {6'b000000, off, 2'b00};
  endfunction

  function automatic logic [accel_pkg::IO_ADDR_W-1:0] ip_reg(accel_pkg::reg_off_e off);
    return {6'b100000, off, 2'b00};
  endfunction

  task automatic finish_run();
    int unsigned prop_fails;
    prop_fails = u_accel_wrap.u_dma.u_props.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic check_word(input string name, input logic [accel_pkg::IO_DATA_W-1:0] exp,
                            input logic [accel_pkg::IO_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("FAIL %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_index(input string name, input logic [accel_pkg::IDX_W-1:0] exp,
                             input logic [accel_pkg::IDX_W-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("FAIL %s: expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic io_write(input logic [accel_pkg::IO_ADDR_W-1:0] addr,
                          input logic [accel_pkg::IO_DATA_W-1:0] data);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_addr    <= addr;
    io_wr_data <= data;
    @(posedge clk);
    io_en      <= 1'b0;
    io_wen     <= 1'b0;
  endtask

  // address stays put until the response, stalled reads included
  task automatic io_read(input logic [accel_pkg::IO_ADDR_W-1:0] addr,
                         output logic [accel_pkg::IO_DATA_W-1:0] data);
    int waited;
    @(posedge clk);
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= addr;
    @(posedge clk);
    io_en   <= 1'b0;
    waited = 0;
    @(posedge clk);
    while (!io_rd_valid && waited < RD_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    data = io_rd_data;
    if (!io_rd_valid) begin
      $display("timeout: no read response from address %h", addr);
      errors++;
      finish_run();
    end
  endtask

  task automatic wait_bits(input string name, input logic [accel_pkg::IO_ADDR_W-1:0] addr,
                           input logic [accel_pkg::IO_DATA_W-1:0] mask);
    logic [accel_pkg::IO_DATA_W-1:0] data;
    int polls;
    polls = 0;
    io_read(addr, data);
    while ((data & mask) != mask && polls < POLL_LIMIT) begin
      io_read(addr, data);
      polls++;
    end
    if ((data & mask) != mask) begin
      $display("timeout: %s never saw bits %h at address %h", name, mask, addr);
      errors++;
      finish_run();
    end
  endtask

  task automatic start_job(input int base, input int len);
    io_write(cmd_reg(accel_pkg::OFF_ADDR), base);
    io_write(cmd_reg(accel_pkg::OFF_LEN), len);
    io_write(cmd_reg(accel_pkg::OFF_CTRL), 32'h1);
  endtask

  // packet byte j lives in lane j%4 of word base + j/4
  task automatic put_byte(input int base, input int j, input logic [7:0] b);
    pmem[base + j / 4][8 * (j % 4) +: 8] = b;
  endtask

  task automatic test_readback();
    logic [accel_pkg::IO_DATA_W-1:0] data;
    io_read(cmd_reg(accel_pkg::OFF_CTRL), data);
    check_word("reset status", 32'h0, data);
    io_read(AGG_STATUS, data);
    check_word("reset aggregated status", 32'h0, data);
    io_write(cmd_reg(accel_pkg::OFF_LEN), 32'h1234);
    io_write(cmd_reg(accel_pkg::OFF_ADDR), 32'h2A5);
    io_write(cmd_reg(accel_pkg::OFF_PATTERN), PAT);
    io_read(cmd_reg(accel_pkg::OFF_LEN), data);
    check_word("len readback", 32'h1234, data);
    io_read(cmd_reg(accel_pkg::OFF_ADDR), data);
    check_word("addr readback", 32'h2A5, data);
    io_read(cmd_reg(accel_pkg::OFF_PATTERN), data);
    check_word("pattern readback", PAT, data);
  endtask

  task automatic test_match();
    logic [accel_pkg::IO_DATA_W-1:0] data;
    int plant_at;
    plant_at = 17;
    for (int i = 0; i < 4; i++)
      put_byte(16, plant_at + i, PAT[8 * i +: 8]);
    start_job(16, 41);
    io_read(cmd_reg(accel_pkg::OFF_MATCH_IDX), data);
    check_index("match index", accel_pkg::IDX_W'(plant_at + 3), data[accel_pkg::IDX_W-1:0]);
    io_read(cmd_reg(accel_pkg::OFF_CTRL), data);
    check_word("match held status", 32'h200, data & 32'h300);
    io_write(cmd_reg(accel_pkg::OFF_RELEASE), 32'h1);
    wait_bits("match done", cmd_reg(accel_pkg::OFF_CTRL), 32'h100);
    io_read(cmd_reg(accel_pkg::OFF_CTRL), data);
    check_word("match final status", 32'h300, data);
    io_read(cmd_reg(accel_pkg::OFF_ERROR), data);
    check_word("match errors", 32'h0, data);
  endtask

  task automatic test_no_match();
    logic [accel_pkg::IO_DATA_W-1:0] data;
    int unsigned rd_before;
    rd_before = rd_count;
    start_job(100, 200);
    io_read(cmd_reg(accel_pkg::OFF_MATCH_IDX), data);
    io_read(cmd_reg(accel_pkg::OFF_CTRL), data);
    check_word("no match status", 32'h100, data);
    check_word("no match words read", 32'd50, rd_count - rd_before);
    io_read(cmd_reg(accel_pkg::OFF_ERROR), data);
    check_word("no match errors", 32'h0, data);
  endtask

  task automatic test_desc_error();
    logic [accel_pkg::IO_DATA_W-1:0] data;
    start_job(20, 0);
    wait_bits("zero length error", cmd_reg(accel_pkg::OFF_ERROR), 32'h1);
    io_read(cmd_reg(accel_pkg::OFF_CTRL), data);
    check_word("zero length status", 32'h0, data);
    start_job(1000, 200);
    wait_bits("out of range error", cmd_reg(accel_pkg::OFF_ERROR), 32'h1);
    io_read(cmd_reg(accel_pkg::OFF_CTRL), data);
    check_word("out of range status", 32'h0, data);
  endtask

  task automatic test_stop();
    logic [accel_pkg::IO_DATA_W-1:0] data;
    int unsigned rd_before;
    rd_before = rd_count;
    start_job(400, 1000);
    wait_bits("stop busy", cmd_reg(accel_pkg::OFF_CTRL), 32'h2);
    io_write(cmd_reg(accel_pkg::OFF_CTRL), 32'h10);
    io_read(cmd_reg(accel_pkg::OFF_MATCH_IDX), data);
    io_read(cmd_reg(accel_pkg::OFF_CTRL), data);
    check_word("stop status", 32'h100, data);
    io_read(cmd_reg(accel_pkg::OFF_ERROR), data);
    check_word("stop errors", 32'h0, data);
    checks++;
    if (rd_count - rd_before >= 250) begin
      $display("FAIL stop words read: expected fewer than 250 actual %0d", rd_count - rd_before);
      errors++;
    end
  endtask

  task automatic test_ip();
    logic [accel_pkg::IO_DATA_W-1:0] data;
    // prefix 192.168.0.0/16 in host order
    io_write(ip_reg(accel_pkg::OFF_LEN), 32'hC0A8_0000);
    io_write(ip_reg(accel_pkg::OFF_ADDR), 32'hFFFF_0000);
    // 192.168.5.7 as it arrives in network order
    io_write(ip_reg(accel_pkg::OFF_CTRL), 32'h0705_A8C0);
    io_read(ip_reg(accel_pkg::OFF_CTRL), data);
    check_word("ip inside prefix", 32'h1, data);
    // 10.1.2.3
    io_write(ip_reg(accel_pkg::OFF_CTRL), 32'h0302_010A);
    io_read(ip_reg(accel_pkg::OFF_CTRL), data);
    check_word("ip outside prefix", 32'h0, data);
    io_read(AGG_STATUS, data);
    check_word("ip status bits", 32'h1_0000, data & 32'h3_0000);
  endtask

  initial begin
    rst         = 1'b1;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_addr     = '0;
    io_wr_data  = '0;
    mem_rd_data = '0;
    errors      = 0;
    checks      = 0;
    void'($urandom(40));
    // packet bytes below 0x80 never form the pattern by chance
    for (int i = 0; i < (1 << accel_pkg::PMEM_ADDR_W); i++)
      pmem[i] = $urandom & 32'h7F7F_7F7F;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_readback();
    test_match();
    test_no_match();
    test_desc_error();
    test_stop();
    test_ip();
    repeat (5) @(posedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/accel_pkg.sv
source/accel_mmio_regs.sv
source/pmem_rd_dma.sv
source/byte_pattern_matcher.sv
source/ip_prefix_matcher.sv
source/accel_status.sv
source/accel_wrap.sv
testbench/accel_props.sv
testbench/accel_tb.sv
